// File: all.f
+incdir+verif
logic/fir_pkg.sv
logic/tap_counter.sv
logic/sample_ram.sv
logic/fir_sequencer.sv
logic/mac_unit.sv
logic/fir_top.sv
verif/fir_tb.sv

// File: logic/fir_pkg.sv
/*
 * Shared word widths, signed word types and sequencer states
 * for the single-MAC FIR filter
 */
package fir_pkg;

	// Word widths
	parameter int DATA_W = 16;	// Input sample and dout
	parameter int COEF_W = 17;	// One coefficient
	parameter int ACC_W  = 40;	// Full product plus 7 guard bits, up to 128 taps

	// Input sample or scaled output
	typedef logic signed [DATA_W-1:0] sample_t;

	// One tap coefficient
	typedef logic signed [COEF_W-1:0] coef_t;

	// Raw accumulated sum
	typedef logic signed [ACC_W-1:0] acc_t;

	// Sequencer states
	typedef enum logic [2:0] {
		CLEAR = 3'd0,	// Zero the sample history after reset
		IDLE  = 3'd1,	// Ready, takes a sample or a coefficient
		WRITE = 3'd2,	// Latched sample goes into the data RAM
		MAC   = 3'd3,	// One tap issued per cycle
		WAIT  = 3'd4	// Pipeline drains until the valid pulse
	} seq_state_t;

endpackage

// File: logic/fir_sequencer.sv
/*
 * FIR state machine with sample latch and circular write pointer
 * Drives RAM addresses, write enables and MAC issue flags
 */
`timescale 1ns/10ps
module fir_sequencer import fir_pkg::*; #(
	parameter int NUM_TAPS = 64
) (
	input  logic                        alu_clk,
	input  logic                        clk_fast,	// Async reset, active low
	input  logic                        valid_in,	// Sample offered
	input  logic                        cload,		// Coefficient write request
	input  sample_t                     din,
	input  logic [$clog2(NUM_TAPS)-1:0] tap_idx,	// From tap_counter
	input  logic                        tap_last,	// From tap_counter
	input  logic                        mac_valid,	// Result pulse, ends WAIT
	input  logic [$clog2(NUM_TAPS)-1:0] caddr,
	output logic                        cnt_start,
	output logic                        ready,
	output logic [$clog2(NUM_TAPS)-1:0] data_addr,
	output logic                        data_we,
	output sample_t                     data_wdata,
	output logic [$clog2(NUM_TAPS)-1:0] coef_addr,
	output logic                        coef_we,
	output logic                        tap_issue,	// Address pair valid this cycle
	output logic                        tap_first,
	output logic                        tap_last_out
);

	localparam int AW = $clog2(NUM_TAPS);

	seq_state_t state;
	logic [AW-1:0] wr_ptr;	// Location of the newest sample
	sample_t din_r;		// Accepted sample
	logic accept;

	// Handshakes, cload wins over valid_in
	assign ready   = (state == IDLE);
	assign accept  = ready && valid_in && !cload;
	assign coef_we = ready && cload;

	// State register and write pointer
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			state  <= CLEAR;
			wr_ptr <= '0;
		end else begin
			case (state)
				CLEAR: if (tap_last) state <= IDLE;	// Every location zeroed
				IDLE:  if (accept) state <= WRITE;
				WRITE: begin
					state  <= MAC;
					wr_ptr <= wr_ptr + 1'b1;	// Once per sample
				end
				MAC:   if (tap_last) state <= WAIT;
				WAIT:  if (mac_valid) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// Sample latch
	always_ff @(posedge alu_clk) begin
		if (accept)
			din_r <= din;
	end

	// Counter restarts for the MAC phase
	assign cnt_start = (state == WRITE);

	// Data RAM port
	always_comb begin
		case (state)
			CLEAR:   data_addr = tap_idx;		// Sweep all locations
			WRITE:   data_addr = wr_ptr + 1'b1;	// Next slot in the ring
			MAC:     data_addr = wr_ptr - tap_idx;	// Tap k is k samples back, wraps
			default: data_addr = wr_ptr;
		endcase
	end
	assign data_we    = (state == CLEAR) || (state == WRITE);
	assign data_wdata = (state == CLEAR) ? '0 : din_r;

	// Coefficient RAM address, external while idle
	assign coef_addr = (state == MAC) ? tap_idx : caddr;

	// Issue flags, same cycle as the RAM addresses
	assign tap_issue    = (state == MAC);
	assign tap_first    = tap_issue && (tap_idx == '0);
	assign tap_last_out = tap_issue && tap_last;

endmodule

// File: logic/fir_top.sv
/*
 * FIR filter top level with sequencer, counter, data and coefficient RAMs
 * and MAC datapath
 */
`timescale 1ns/10ps
module fir_top import fir_pkg::*; #(
	parameter int NUM_TAPS  = 64,	// Power of two
	parameter int OUT_SHIFT = 15	// Accumulator to dout scaling
) (
	input  logic                        alu_clk,
	input  logic                        clk_fast,	// Async reset, active low
	input  sample_t                     din,
	input  logic                        valid_in,
	input  coef_t                       cin,
	input  logic [$clog2(NUM_TAPS)-1:0] caddr,
	input  logic                        cload,
	output logic                        ready,
	output sample_t                     dout,
	output acc_t                        dout_raw,
	output logic                        valid
);

	localparam int AW = $clog2(NUM_TAPS);

	logic cnt_start;
	logic [AW-1:0] tap_idx;
	logic tap_last;
	logic [AW-1:0] data_addr;
	logic data_we;
	sample_t data_wdata;
	sample_t data_rdata;
	logic [AW-1:0] coef_addr;
	logic coef_we;
	coef_t coef_rdata;
	logic tap_issue;
	logic tap_first;
	logic tap_last_mac;	// Last flag gated by MAC state

	fir_sequencer #(.NUM_TAPS(NUM_TAPS)) seq_i (
		.alu_clk     (alu_clk),
		.clk_fast    (clk_fast),
		.valid_in    (valid_in),
		.cload       (cload),
		.din         (din),
		.tap_idx     (tap_idx),
		.tap_last    (tap_last),
		.mac_valid   (valid),
		.caddr       (caddr),
		.cnt_start   (cnt_start),
		.ready       (ready),
		.data_addr   (data_addr),
		.data_we     (data_we),
		.data_wdata  (data_wdata),
		.coef_addr   (coef_addr),
		.coef_we     (coef_we),
		.tap_issue   (tap_issue),
		.tap_first   (tap_first),
		.tap_last_out(tap_last_mac)
	);

	tap_counter #(.NUM_TAPS(NUM_TAPS)) cnt_i (
		.alu_clk (alu_clk),
		.clk_fast(clk_fast),
		.start   (cnt_start),
		.tap_idx (tap_idx),
		.last    (tap_last)
	);

	// Circular sample history
	sample_ram #(.word_t(sample_t), .NUM_TAPS(NUM_TAPS)) data_ram_i (
		.alu_clk(alu_clk),
		.addr   (data_addr),
		.we     (data_we),
		.wdata  (data_wdata),
		.rdata  (data_rdata)
	);

	// Coefficients, written straight from cin
	sample_ram #(.word_t(coef_t), .NUM_TAPS(NUM_TAPS)) coef_ram_i (
		.alu_clk(alu_clk),
		.addr   (coef_addr),
		.we     (coef_we),
		.wdata  (cin),
		.rdata  (coef_rdata)
	);

	mac_unit #(.OUT_SHIFT(OUT_SHIFT)) mac_i (
		.alu_clk  (alu_clk),
		.clk_fast (clk_fast),
		.sample   (data_rdata),
		.coef     (coef_rdata),
		.tap_issue(tap_issue),
		.tap_first(tap_first),
		.tap_last (tap_last_mac),
		.dout     (dout),
		.dout_raw (dout_raw),
		.valid    (valid)
	);

endmodule

// File: logic/mac_unit.sv
/*
 * Pipelined multiply-accumulate with output scaling and saturation
 * Issue to accumulator in 3 cycles, output register and valid pulse
 */
`timescale 1ns/10ps
module mac_unit import fir_pkg::*; #(
	parameter int OUT_SHIFT = 15
) (
	input  logic    alu_clk,
	input  logic    clk_fast,	// Async reset, active low
	input  sample_t sample,		// Data RAM read word
	input  coef_t   coef,		// Coefficient RAM read word
	input  logic    tap_issue,
	input  logic    tap_first,
	input  logic    tap_last,
	output sample_t dout,		// Scaled and saturated
	output acc_t    dout_raw,	// Full sum
	output logic    valid		// One pulse per sample
);

	localparam acc_t SAT_HI = acc_t'({1'b0, {(DATA_W-1){1'b1}}});
	localparam acc_t SAT_LO = -SAT_HI - acc_t'(1);

	logic [1:0] issue_d;	// Bit 0 aligned with RAM data, bit 1 with product
	logic [1:0] first_d;
	logic [2:0] last_d;	// Bit 2 aligned with the finished sum
	logic signed [DATA_W+COEF_W-1:0] prod_r;
	acc_t acc;
	acc_t shifted;
	sample_t sat;

	// Flag pipeline
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			issue_d <= '0;
			first_d <= '0;
			last_d  <= '0;
			valid   <= 1'b0;
		end else begin
			issue_d <= {issue_d[0], tap_issue};
			first_d <= {first_d[0], tap_first};
			last_d  <= {last_d[1:0], tap_last};
			valid   <= last_d[2];
		end
	end

	// Product register, RAM words arrive one cycle after issue
	always_ff @(posedge alu_clk) begin
		if (issue_d[0])
			prod_r <= sample * coef;
	end

	// Accumulator, first product replaces the old sum
	always_ff @(posedge alu_clk) begin
		if (issue_d[1])
			acc <= first_d[1] ? acc_t'(prod_r) : acc + acc_t'(prod_r);
	end

	// Scale down and clamp to the sample range
	always_comb begin
		shifted = acc >>> OUT_SHIFT;
		if (shifted > SAT_HI)
			sat = sample_t'(SAT_HI);
		else if (shifted < SAT_LO)
			sat = sample_t'(SAT_LO);
		else
			sat = sample_t'(shifted);
	end

	// Output register, held until the next result
	always_ff @(posedge alu_clk) begin
		if (last_d[2]) begin
			dout_raw <= acc;
			dout     <= sat;
		end
	end

endmodule

// File: logic/sample_ram.sv
/*
 * Single-port synchronous RAM with registered read
 * Word type set per instance, one word per tap
 */
`timescale 1ns/10ps
module sample_ram #(
	parameter type word_t   = logic [15:0],
	parameter int  NUM_TAPS = 64
) (
	input  logic                        alu_clk,
	input  logic [$clog2(NUM_TAPS)-1:0] addr,
	input  logic                        we,
	input  word_t                       wdata,
	output word_t                       rdata		// Valid one cycle after addr
);

	// Storage array
	word_t mem [NUM_TAPS];

	// Write port
	always_ff @(posedge alu_clk) begin
		if (we)
			mem[addr] <= wdata;
	end

	// Registered read, old data on a same-address write
	always_ff @(posedge alu_clk) begin
		rdata <= mem[addr];
	end

endmodule

// File: logic/tap_counter.sv
/*
 * Phase counter for the FIR sequencer
 * Gives the tap index and a last-tap flag for clear and MAC phases
 */
`timescale 1ns/10ps
module tap_counter #(
	parameter int NUM_TAPS = 64
) (
	input  logic                        alu_clk,
	input  logic                        clk_fast,	// Async reset, active low
	input  logic                        start,		// Restart from tap 0
	output logic [$clog2(NUM_TAPS)-1:0] tap_idx,
	output logic                        last		// Final count cycle of a phase
);

	localparam int AW = $clog2(NUM_TAPS);
	localparam logic [AW-1:0] LAST_IDX = AW'(NUM_TAPS - 1);

	logic running;	// Phase in progress

	// Counter comes out of reset already running, which times the clear phase
	always_ff @(posedge alu_clk or negedge clk_fast) begin
		if (!clk_fast) begin
			tap_idx <= '0;
			running <= 1'b1;
		end else if (start) begin
			tap_idx <= '0;
			running <= 1'b1;
		end else if (running) begin
			if (tap_idx == LAST_IDX)
				running <= 1'b0;	// Hold on the last index
			else
				tap_idx <= tap_idx + 1'b1;
		end
	end

	assign last = running && (tap_idx == LAST_IDX);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build the FIR testbench with Verilator, run it, pass only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module fir_tb -f all.f -o fir_sim \
	&& ./obj_dir/fir_sim | tee /dev/stderr | grep -qx "Done: no errors" \
	&& { echo "Simulation passed"; exit 0; } \
	|| { echo "Simulation failed"; exit 1; }

// File: verif/fir_tb_checks.svh
/*
 * Typed compare tasks for flags, counts, samples and sums
 * Bounded wait on ready or valid
 */
`ifndef FIR_TB_CHECKS_SVH
`define FIR_TB_CHECKS_SVH

task automatic check_flag(input logic got, input logic exp, input string what);
	n_tests++;
	if (got !== exp) begin
		n_errors++;
		$display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
	end else
		$display("ok      %s = %b", what, got);
endtask

task automatic check_count(input int got, input int exp, input string what);
	n_tests++;
	if (got != exp) begin
		n_errors++;
		$display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
	end else
		$display("ok      %s = %0d", what, got);
endtask

task automatic check_sample(input sample_t got, input sample_t exp, input string what);
	n_tests++;
	if (got !== exp) begin
		n_errors++;
		$display("FAILED at %0t ns: %s dout %0d, expected %0d", $time, what, got, exp);
	end else
		$display("ok      %s dout %0d", what, got);
endtask

task automatic check_acc(input acc_t got, input acc_t exp, input string what);
	n_tests++;
	if (got !== exp) begin
		n_errors++;
		$display("FAILED at %0t ns: %s dout_raw %0d, expected %0d", $time, what, got, exp);
	end else
		$display("ok      %s dout_raw %0d", what, got);
endtask

// Steps falling edges until ready (sel 0) or valid (sel 1) is high
task automatic wait_flag(input bit sel, input string what, output int cycles);
	cycles = 0;
	while ((sel ? valid : ready) !== 1'b1 && cycles < WAIT_LIMIT) begin
		@(negedge alu_clk);
		cycles++;
	end
	if ((sel ? valid : ready) !== 1'b1) begin
		timed_out = 1'b1;
		$display("Timeout: no %s within %0d cycles, sequencer stuck in state %s",
			what, WAIT_LIMIT, dut_i.seq_i.state.name());
	end
endtask

`endif

// File: verif/fir_tb.sv
/*
 * FIR filter testbench with clock, reset, stimulus table loop,
 * reference model and closing report
 */
`timescale 1ns/10ps
module fir_tb import fir_pkg::*; ();

	localparam int NUM_TAPS   = 16;
	localparam int OUT_SHIFT  = 15;
	localparam int AW         = $clog2(NUM_TAPS);
	localparam int WAIT_LIMIT = 4 * NUM_TAPS + 40;	// Cycles before a wait gives up
	localparam logic [1:0] LOAD  = 2'd0;	// Coefficient write
	localparam logic [1:0] PUSH  = 2'd1;	// Sample with valid_in raised for it
	localparam logic [1:0] EARLY = 2'd2;	// Sample with valid_in already high

	typedef struct packed {
		logic [1:0]          kind;
		logic [2:0]          test;
		logic [AW-1:0]       addr;
		logic signed [31:0]  value;	// Coefficient or sample
		logic [1:0]          chk;	// Table checks on dout_raw (bit 0) and dout (bit 1)
		acc_t                exp_raw;
		sample_t             exp_dout;
	} row_t;

	logic alu_clk;
	logic clk_fast;
	sample_t din;
	logic valid_in;
	coef_t cin;
	logic [AW-1:0] caddr;
	logic cload;
	logic ready;
	sample_t dout;
	acc_t dout_raw;
	logic valid;

	row_t rows [$];
	coef_t model_coef [NUM_TAPS];
	sample_t hist [NUM_TAPS];	// Index 0 is the newest sample
	int seed;
	int n_tests = 0;
	int n_errors = 0;
	int n_accepts = 0;	// Edges that took a sample
	int n_pulses = 0;
	int n_pushes = 0;
	logic timed_out;

	`include "fir_tb_checks.svh"

	fir_top #(.NUM_TAPS(NUM_TAPS), .OUT_SHIFT(OUT_SHIFT)) dut_i (
		.alu_clk (alu_clk),
		.clk_fast(clk_fast),
		.din     (din),
		.valid_in(valid_in),
		.cin     (cin),
		.caddr   (caddr),
		.cload   (cload),
		.ready   (ready),
		.dout    (dout),
		.dout_raw(dout_raw),
		.valid   (valid)
	);

	always #20 alu_clk = ~alu_clk;	// 40 ns period

	// Handshake monitor sampling half a cycle before the acting edge
	always @(negedge alu_clk) begin
		if (clk_fast && ready && valid_in && !cload)
			n_accepts++;
		if (clk_fast && valid)
			n_pulses++;
	end

	function automatic void add_row(input logic [1:0] kind, input int test, input int addr,
		input int value, input logic [1:0] chk = 2'b00, input acc_t exp_raw = '0,
		input sample_t exp_dout = '0);
		rows.push_back(row_t'{kind, 3'(test), AW'(addr), value, chk, exp_raw, exp_dout});
	endfunction

	// Sum over k of coefficient k times the sample k pushes ago
	function automatic longint model_sum();
		longint sum;
		sum = 0;
		for (int k = 0; k < NUM_TAPS; k++)
			sum += longint'(model_coef[k]) * longint'(hist[k]);
		return sum;
	endfunction

	function automatic sample_t model_out(input longint sum);
		longint q;
		q = sum >>> OUT_SHIFT;
		if (q > 32767)
			q = 32767;	// Clamp high
		else if (q < -32768)
			q = -32768;
		return sample_t'(q);
	endfunction

	task automatic build_table();
		longint sum;
		// Test 2 impulse with coefficient k set to 100 * (k + 1)
		for (int k = 0; k < NUM_TAPS; k++)
			add_row(LOAD, 2, k, 100 * (k + 1));
		for (int k = 0; k < NUM_TAPS; k++)
			add_row(PUSH, 2, 0, (k == 0) ? 32767 : 0, 2'b11, acc_t'(100 * (k + 1) * 32767),
				sample_t'((100 * (k + 1) * 32767) >>> OUT_SHIFT));
		// Test 3 random data where 24 pushes wrap the history
		for (int k = 0; k < NUM_TAPS; k++)
			add_row(LOAD, 3, k, $random(seed) % 8192);
		for (int n = 0; n < 24; n++)
			add_row((n % 4 == 3) ? EARLY : PUSH, 3, 0, int'(sample_t'($random(seed))));
		// Test 4 saturation with a full history of extremes on the last rows
		for (int k = 0; k < NUM_TAPS; k++)
			add_row(LOAD, 4, k, 65535);
		for (int n = 0; n < NUM_TAPS; n++)
			add_row(PUSH, 4, 0, 32767, (n == NUM_TAPS - 1) ? 2'b11 : (n >= 12) ? 2'b10 : 2'b00,
				acc_t'(longint'(NUM_TAPS) * 65535 * 32767), 16'sh7fff);
		for (int n = 0; n < NUM_TAPS; n++)
			add_row(PUSH, 4, 0, -32768, (n == NUM_TAPS - 1) ? 2'b11 : (n >= 12) ? 2'b10 : 2'b00,
				acc_t'(longint'(NUM_TAPS) * 65535 * (-32768)), 16'sh8000);
		// Test 5 reload while the history is all -32768
		sum = 0;
		for (int k = 0; k < NUM_TAPS; k++) begin
			add_row(LOAD, 5, k, (k - 8) * 50);
			sum += (k == 0) ? longint'((k - 8) * 50 * 1000) : longint'((k - 8) * 50) * (-32768);
		end
		add_row(PUSH, 5, 0, 1000, 2'b01, acc_t'(sum));
		add_row(LOAD, 5, 1, 3000);	// Single tap change
		add_row(PUSH, 5, 0, -500);
		// Test 6 back-pressure with valid_in never dropping
		add_row(PUSH, 6, 0, int'(sample_t'($random(seed))));
		for (int n = 0; n < 5; n++)
			add_row(EARLY, 6, 0, int'(sample_t'($random(seed))));
	endtask

	task automatic load_row(input int i);
		int waited;
		@(posedge alu_clk);
		cload <= 1'b1;
		caddr <= rows[i].addr;
		cin   <= coef_t'(rows[i].value);
		@(negedge alu_clk);
		wait_flag(1'b0, "ready for a coefficient", waited);
		if (timed_out)
			return;
		@(posedge alu_clk);	// Write edge
		cload <= 1'b0;
		model_coef[rows[i].addr] = coef_t'(rows[i].value);
	endtask

	task automatic push_row(input int i);
		int waited;
		int lat;
		longint sum;
		string tag;
		tag = $sformatf("test %0d row %0d", rows[i].test, i);
		if (rows[i].kind == PUSH) begin
			@(posedge alu_clk);
			din      <= sample_t'(rows[i].value);
			valid_in <= 1'b1;
			@(negedge alu_clk);
		end
		wait_flag(1'b0, "ready for a sample", waited);
		if (timed_out)
			return;
		@(posedge alu_clk);	// Acceptance edge
		n_pushes++;
		for (int k = NUM_TAPS - 1; k > 0; k--)
			hist[k] = hist[k - 1];
		hist[0] = sample_t'(rows[i].value);
		if (i + 1 < rows.size() && rows[i + 1].kind == EARLY)
			din <= sample_t'(rows[i + 1].value);	// Next one waits on back-pressure
		else
			valid_in <= 1'b0;
		@(negedge alu_clk);
		wait_flag(1'b1, "valid pulse", lat);
		if (timed_out)
			return;
		sum = model_sum();
		check_count(lat, NUM_TAPS + 4, {tag, " latency"});
		check_acc(dout_raw, acc_t'(sum), {tag, " model"});
		check_sample(dout, model_out(sum), {tag, " model"});
		if (rows[i].chk[0])
			check_acc(dout_raw, rows[i].exp_raw, {tag, " table"});
		if (rows[i].chk[1])
			check_sample(dout, rows[i].exp_dout, {tag, " table"});
		@(negedge alu_clk);
		check_flag(valid, 1'b0, {tag, " valid one cycle"});
		check_flag(ready, 1'b1, {tag, " ready after valid"});
	endtask

	initial begin
		int waited;
		alu_clk   = 1'b0;
		clk_fast  = 1'b0;
		din       = '0;
		valid_in  = 1'b0;
		cin       = '0;
		caddr     = '0;
		cload     = 1'b0;
		timed_out = 1'b0;
		seed      = 32'h8277ba84;
		for (int k = 0; k < NUM_TAPS; k++)
			hist[k] = '0;	// Matches the clear phase
		build_table();

		// Test 1 reset and clear phase
		repeat (15) @(posedge alu_clk);
		@(negedge alu_clk);
		check_flag(ready, 1'b0, "test 1 ready in reset");
		check_flag(valid, 1'b0, "test 1 valid in reset");
		@(posedge alu_clk);
		clk_fast <= 1'b1;	// 16th edge still sees reset
		@(negedge alu_clk);
		check_flag(ready, 1'b0, "test 1 ready in clear");
		wait_flag(1'b0, "ready after reset", waited);
		if (!timed_out)
			check_count(waited, NUM_TAPS, "test 1 clear cycles");

		for (int i = 0; i < rows.size() && !timed_out; i++) begin
			if (rows[i].kind == LOAD)
				load_row(i);
			else
				push_row(i);
		end
		if (!timed_out) begin
			repeat (4) @(negedge alu_clk);
			check_count(n_accepts, n_pushes, "test 6 accepted samples");
			check_count(n_pulses, n_pushes, "test 6 valid pulses");
		end

		$display("Checks run: %0d, failed: %0d, samples pushed: %0d", n_tests, n_errors, n_pushes);
		if (n_errors == 0 && !timed_out)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
